// File: Bender.yml
package:
  name: memspeed

sources:
  - memspeed_pkg.sv
  - traffic_gen.sv
  - port_arbiter.sv
  - mem_backend.sv
  - speed_counters.sv
  - memspeed_top.sv
  - target: simulation
    files:
      - memspeed_tb.sv

// File: build.f
memspeed_pkg.sv
traffic_gen.sv
port_arbiter.sv
mem_backend.sv
speed_counters.sv
memspeed_top.sv
memspeed_tb.sv

// File: mem_backend.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// on-chip stand-in for the SDRAM controller with a
// fixed access latency, upper address half unmapped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mem_backend #(
  parameter int ADDR_W  = memspeed_pkg::addr_w,
  parameter int LATENCY = 3
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             mem_req,
  input  logic                             mem_we,
  input  logic [ADDR_W-1:0]                mem_addr,
  input  logic [memspeed_pkg::data_w-1:0] mem_wdata,
  output logic                             mem_ack,
  output logic [memspeed_pkg::data_w-1:0] mem_rdata
);
  import memspeed_pkg::*;

  localparam int words = 2 ** (ADDR_W - 1);

  logic [data_w-1:0] mem [words];
  logic              mem_req_q;
  logic              enter;
  logic [LATENCY-1:0] pipe_v;
  logic              pipe_we    [LATENCY];
  logic [ADDR_W-2:0] pipe_addr  [LATENCY];
  logic [data_w-1:0] pipe_wdata [LATENCY];

  initial begin
    for (int i = 0; i < words; i++) begin
      mem[i] = '0;
    end
  end

  // a request counts once, on the cycle mem_req rises
  assign enter = mem_req && !mem_req_q && !mem_addr[ADDR_W-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_req_q <= 1'b0;
      pipe_v    <= '0;
    end else begin
      mem_req_q <= mem_req;
      pipe_v[0] <= enter;
      for (int k = 1; k < LATENCY; k++) begin
        pipe_v[k] <= pipe_v[k-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    pipe_we[0]    <= mem_we;
    pipe_addr[0]  <= mem_addr[ADDR_W-2:0];
    pipe_wdata[0] <= mem_wdata;
    for (int k = 1; k < LATENCY; k++) begin
      pipe_we[k]    <= pipe_we[k-1];
      pipe_addr[k]  <= pipe_addr[k-1];
      pipe_wdata[k] <= pipe_wdata[k-1];
    end
    if (pipe_v[LATENCY-1] && pipe_we[LATENCY-1]) begin
      mem[pipe_addr[LATENCY-1]] <= pipe_wdata[LATENCY-1];
    end
  end

  assign mem_ack   = pipe_v[LATENCY-1];
  assign mem_rdata = mem[pipe_addr[LATENCY-1]];  // valid while mem_ack is high

endmodule

`default_nettype wire

// File: memspeed_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, scramble constants and register map
// of the memory speedometer, imported by every block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package memspeed_pkg;

  localparam int addr_w  = 10;  // top bit selects the unmapped half
  localparam int data_w  = 64;
  localparam int count_w = 24;

  localparam int axi_addr_w = 8;
  localparam int axi_data_w = 32;

  // xored into the transaction count to spread the ports over memory
  localparam logic [addr_w-1:0] inst_scramble = 10'h234;
  localparam logic [addr_w-1:0] data_scramble = 10'h345;

  localparam logic [axi_addr_w-1:0] reg_ctrl        = 8'h00;  // bit 0 starts a run
  localparam logic [axi_addr_w-1:0] reg_limit       = 8'h04;
  localparam logic [axi_addr_w-1:0] reg_status      = 8'h08;  // bit 0 done, bit 1 run
  localparam logic [axi_addr_w-1:0] reg_cycles      = 8'h0C;
  localparam logic [axi_addr_w-1:0] reg_acks        = 8'h10;
  localparam logic [axi_addr_w-1:0] reg_timeouts    = 8'h14;
  localparam logic [axi_addr_w-1:0] reg_checksum_lo = 8'h18;
  localparam logic [axi_addr_w-1:0] reg_checksum_hi = 8'h1C;

  typedef enum logic [1:0] {
    op_inst_read  = 2'd0,
    op_data_read  = 2'd1,
    op_data_write = 2'd2
  } op_t;

endpackage

`default_nettype wire

// File: memspeed_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for memspeed_top, starts runs over AXI4-Lite
// and checks the result registers against a memory model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module memspeed_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import memspeed_pkg::*;

  localparam int tb_addr_w  = 10;
  localparam int latency    = 3;
  localparam int tmo_cycles = 12;
  localparam int n_runs     = 4;

  typedef struct packed {
    logic [23:0] limit;
    logic        slow;  // random BREADY and RREADY delays
  } run_row_t;

  // an index reaches the mapped half only with bit 9 set
  run_row_t run_table [n_runs] = '{
    '{24'd8,    1'b0},
    '{24'd600,  1'b1},
    '{24'd1024, 1'b0},
    '{24'd700,  1'b1}
  };

  logic        clk;
  logic        rst;
  logic [7:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [7:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  logic [63:0] model_mem [2**(tb_addr_w-1)];  // kept across runs like the DUT memory
  int          seed = 67842;
  int          checks;
  int          mismatches;
  int          failures;

  memspeed_top #(
    .ADDR_W         (tb_addr_w),
    .LATENCY        (latency),
    .TIMEOUT_CYCLES (tmo_cycles)
  ) DUT (
    .clk     (clk),
    .rst     (rst),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t ns: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
    end
  endtask

  task automatic report_failure(input string msg);
    failures++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  task automatic stall_cycles(input logic slow);
    int n;
    if (slow) begin
      n = 1 + $unsigned($random(seed)) % 4;  // one to four cycles of back-pressure
      repeat (n) @(posedge clk);
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           input logic slow);
    int n;
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hF;
    wvalid  <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!awready && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!awready) begin
      report_failure("write address and data were never accepted");
    end
    @(posedge clk);  // handshake edge when awready was seen
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    stall_cycles(slow);
    bready <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!bvalid && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!bvalid) begin
      report_failure("no write response arrived");
    end else begin
      check_value("bresp", 64'(bresp), 64'h0);
    end
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, input logic slow,
                          output logic [31:0] data);
    int n;
    data = '0;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!arready && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!arready) begin
      report_failure("read address was never accepted");
    end
    @(posedge clk);
    arvalid <= 1'b0;
    stall_cycles(slow);
    rready <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!rvalid && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!rvalid) begin
      report_failure("no read data arrived");
    end else begin
      data = rdata;
      check_value("rresp", 64'(rresp), 64'h0);
    end
    @(posedge clk);
    rready <= 1'b0;
  endtask

  // replays the transaction pattern against the model memory
  task automatic model_run(input int limit, output int acks, output int tmos,
                           output logic [63:0] sum);
    logic [31:0]          idx;
    logic [tb_addr_w-1:0] a;
    logic                 is_write;
    acks = 0;
    tmos = 0;
    sum  = '0;
    for (int i = 0; i < limit; i++) begin
      idx      = i;
      is_write = (idx[1:0] == 2'b11);
      if (is_write || idx[0]) begin
        a = idx[tb_addr_w-1:0] ^ data_scramble;
      end else begin
        a = idx[tb_addr_w-1:0] ^ inst_scramble;
      end
      if (a[tb_addr_w-1]) begin  // unmapped half never answers
        tmos++;
      end else begin
        acks++;
        if (is_write) begin
          model_mem[a[tb_addr_w-2:0]] = {4{idx[15:0]}};
        end else begin
          sum = sum ^ model_mem[a[tb_addr_w-2:0]];
        end
      end
    end
  endtask

  task automatic wait_run_done(input int limit, input logic slow);
    logic [31:0] status;
    int          polls;
    polls  = 0;
    status = '0;
    while (!status[0] && polls < limit * (tmo_cycles + 4) + 100) begin
      read_reg(reg_status, slow, status);
      polls++;
    end
    if (!status[0]) begin
      report_failure("run never set the done bit in status");
    end
  endtask

  initial begin
    int budget;
    budget = 4000;
    for (int r = 0; r < n_runs; r++) begin
      budget += run_table[r].limit * (tmo_cycles + 4);
    end
    repeat (budget) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles, the test did not complete", budget);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    logic [31:0] word;
    logic [31:0] sum_lo;
    logic [31:0] sum_hi;
    logic [63:0] sum_exp;
    int          acks_exp;
    int          tmos_exp;
    int          acks_dut;
    int          tmos_dut;
    int          lo_bound;
    int          hi_bound;
    checks     = 0;
    mismatches = 0;
    failures   = 0;
    rst        = 1'b1;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    for (int k = 0; k < 2**(tb_addr_w-1); k++) begin
      model_mem[k] = '0;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    read_reg(reg_status, 1'b0, word);
    check_value("status", 64'(word), 64'h0);
    read_reg(reg_cycles, 1'b0, word);
    check_value("cycles", 64'(word), 64'h0);
    read_reg(reg_acks, 1'b0, word);
    check_value("acks", 64'(word), 64'h0);
    read_reg(reg_timeouts, 1'b0, word);
    check_value("timeouts", 64'(word), 64'h0);
    read_reg(reg_checksum_lo, 1'b0, word);
    check_value("checksum_lo", 64'(word), 64'h0);
    read_reg(reg_checksum_hi, 1'b0, word);
    check_value("checksum_hi", 64'(word), 64'h0);

    // limit holds 24 bits, the top byte reads back as zero
    write_reg(reg_limit, 32'hFFAB_CDEF, 1'b0);
    read_reg(reg_limit, 1'b0, word);
    check_value("limit", 64'(word), 64'h00AB_CDEF);
    write_reg(reg_limit, 32'h0012_3456, 1'b1);
    read_reg(reg_limit, 1'b1, word);
    check_value("limit", 64'(word), 64'h0012_3456);

    for (int r = 0; r < n_runs; r++) begin
      write_reg(reg_limit, 32'(run_table[r].limit), run_table[r].slow);
      write_reg(reg_ctrl, 32'h1, run_table[r].slow);
      wait_run_done(run_table[r].limit, run_table[r].slow);
      read_reg(reg_status, run_table[r].slow, word);
      check_value("status", 64'(word), 64'h1);
      model_run(run_table[r].limit, acks_exp, tmos_exp, sum_exp);
      read_reg(reg_acks, run_table[r].slow, word);
      acks_dut = word;
      check_value("acks", 64'(word), 64'(acks_exp));
      read_reg(reg_timeouts, run_table[r].slow, word);
      tmos_dut = word;
      check_value("timeouts", 64'(word), 64'(tmos_exp));
      if (acks_dut + tmos_dut != run_table[r].limit) begin
        report_failure($sformatf("acks plus timeouts is %0d, not the limit %0d",
                                 acks_dut + tmos_dut, run_table[r].limit));
      end
      read_reg(reg_checksum_lo, run_table[r].slow, sum_lo);
      read_reg(reg_checksum_hi, run_table[r].slow, sum_hi);
      check_value("checksum", {sum_hi, sum_lo}, sum_exp);
      read_reg(reg_cycles, run_table[r].slow, word);
      lo_bound = acks_exp * (latency + 2) + tmos_exp * tmo_cycles;
      hi_bound = acks_exp * (latency + 4) + tmos_exp * (tmo_cycles + 4) + 8;
      if (word < lo_bound || word > hi_bound) begin
        report_failure($sformatf("cycles %0d outside %0d to %0d for limit %0d",
                                 word, lo_bound, hi_bound, run_table[r].limit));
      end
    end

    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: memspeed_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory speedometer top, host access over AXI4-Lite
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module memspeed_top #(
  parameter int ADDR_W         = memspeed_pkg::addr_w,
  parameter int LATENCY        = 3,
  parameter int TIMEOUT_CYCLES = 12
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [memspeed_pkg::axi_addr_w-1:0]   awaddr,
  input  logic                                  awvalid,
  output logic                                  awready,
  input  logic [memspeed_pkg::axi_data_w-1:0]   wdata,
  input  logic [memspeed_pkg::axi_data_w/8-1:0] wstrb,
  input  logic                                  wvalid,
  output logic                                  wready,
  output logic [1:0]                            bresp,
  output logic                                  bvalid,
  input  logic                                  bready,
  input  logic [memspeed_pkg::axi_addr_w-1:0]   araddr,
  input  logic                                  arvalid,
  output logic                                  arready,
  output logic [memspeed_pkg::axi_data_w-1:0]   rdata,
  output logic [1:0]                            rresp,
  output logic                                  rvalid,
  input  logic                                  rready
);
  import memspeed_pkg::*;

  logic               run;
  logic [count_w-1:0] limit;
  logic               finished;
  logic               req;
  op_t                op;
  logic [ADDR_W-1:0]  gen_addr;
  logic [data_w-1:0]  gen_wdata;
  logic               tx_done;
  logic               tx_timeout;
  logic [data_w-1:0]  tx_rdata;
  logic               mem_req;
  logic               mem_we;
  logic [ADDR_W-1:0]  mem_addr;
  logic [data_w-1:0]  mem_wdata;
  logic               mem_ack;
  logic [data_w-1:0]  mem_rdata;

  traffic_gen #(
    .ADDR_W (ADDR_W)
  ) u_traffic_gen (
    .clk      (clk),
    .rst      (rst),
    .run      (run),
    .limit    (limit),
    .req      (req),
    .op       (op),
    .addr     (gen_addr),
    .wdata    (gen_wdata),
    .done     (tx_done),
    .timeout  (tx_timeout),
    .finished (finished)
  );

  port_arbiter #(
    .ADDR_W         (ADDR_W),
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) u_port_arbiter (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .op        (op),
    .addr      (gen_addr),
    .wdata     (gen_wdata),
    .done      (tx_done),
    .timeout   (tx_timeout),
    .rdata     (tx_rdata),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  mem_backend #(
    .ADDR_W  (ADDR_W),
    .LATENCY (LATENCY)
  ) u_mem_backend (
    .clk       (clk),
    .rst       (rst),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  speed_counters u_speed_counters (
    .clk      (clk),
    .rst      (rst),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .run      (run),
    .limit    (limit),
    .finished (finished),
    .done     (tx_done),
    .timeout  (tx_timeout),
    .rdata_in (tx_rdata)
  );

endmodule

`default_nettype wire

// File: port_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-transaction memory port, holds mem_req until
// ack or timeout and returns the outcome for one cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module port_arbiter #(
  parameter int ADDR_W         = memspeed_pkg::addr_w,
  parameter int TIMEOUT_CYCLES = 12
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             req,
  input  memspeed_pkg::op_t                op,
  input  logic [ADDR_W-1:0]                addr,
  input  logic [memspeed_pkg::data_w-1:0] wdata,
  output logic                             done,
  output logic                             timeout,
  output logic [memspeed_pkg::data_w-1:0] rdata,
  output logic                             mem_req,
  output logic                             mem_we,
  output logic [ADDR_W-1:0]                mem_addr,
  output logic [memspeed_pkg::data_w-1:0] mem_wdata,
  input  logic                             mem_ack,
  input  logic [memspeed_pkg::data_w-1:0] mem_rdata
);
  import memspeed_pkg::*;

  localparam int wait_w = $clog2(TIMEOUT_CYCLES + 1);

  logic [wait_w-1:0] wait_cnt;
  logic              accept;

  assign accept = req && !mem_req;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_req  <= 1'b0;
      mem_we   <= 1'b0;
      done     <= 1'b0;
      timeout  <= 1'b0;
      wait_cnt <= '0;
    end else begin
      done    <= 1'b0;
      timeout <= 1'b0;
      if (!mem_req) begin
        wait_cnt <= '0;
        if (accept) begin
          mem_req <= 1'b1;
          mem_we  <= (op == op_data_write);
        end
      end else if (mem_ack) begin  // an ack in the last wait cycle still counts
        mem_req <= 1'b0;
        done    <= 1'b1;
      end else if (wait_cnt == wait_w'(TIMEOUT_CYCLES - 1)) begin
        mem_req <= 1'b0;
        timeout <= 1'b1;
      end else begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      mem_addr  <= addr;
      mem_wdata <= wdata;
    end
    if (mem_req && mem_ack) begin
      rdata <= mem_we ? '0 : mem_rdata;
    end
  end

endmodule

`default_nettype wire

// File: speed_counters.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// run control and result counters behind an AXI4-Lite
// register window, see memspeed_pkg for the offsets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module speed_counters (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [memspeed_pkg::axi_addr_w-1:0]  awaddr,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [memspeed_pkg::axi_data_w-1:0]  wdata,
  input  logic [memspeed_pkg::axi_data_w/8-1:0] wstrb,
  input  logic                                 wvalid,
  output logic                                 wready,
  output logic [1:0]                           bresp,
  output logic                                 bvalid,
  input  logic                                 bready,
  input  logic [memspeed_pkg::axi_addr_w-1:0]  araddr,
  input  logic                                 arvalid,
  output logic                                 arready,
  output logic [memspeed_pkg::axi_data_w-1:0]  rdata,
  output logic [1:0]                           rresp,
  output logic                                 rvalid,
  input  logic                                 rready,
  output logic                                 run,
  output logic [memspeed_pkg::count_w-1:0]     limit,
  input  logic                                 finished,
  input  logic                                 done,
  input  logic                                 timeout,
  input  logic [memspeed_pkg::data_w-1:0]      rdata_in
);
  import memspeed_pkg::*;

  logic                  wr_en;
  logic                  start;
  logic                  finished_q;
  logic                  stat_done;
  logic [31:0]           cycles;
  logic [count_w-1:0]    acks;
  logic [count_w-1:0]    timeouts;
  logic [data_w-1:0]     checksum;
  logic [axi_data_w-1:0] rd_word;

  assign wr_en = awready && awvalid && wready && wvalid;
  assign start = wr_en && (awaddr == reg_ctrl) && wstrb[0] && wdata[0];
  assign bresp = 2'b00;
  assign rresp = 2'b00;

  always_ff @(posedge clk) begin
    if (rst) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      limit   <= '0;
    end else begin
      if (awready) begin
        awready <= 1'b0;
        wready  <= 1'b0;
        bvalid  <= 1'b1;
      end else if (awvalid && wvalid && !bvalid) begin
        awready <= 1'b1;
        wready  <= 1'b1;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (wr_en && awaddr == reg_limit) begin
        for (int b = 0; b < count_w / 8; b++) begin
          if (wstrb[b]) begin
            limit[8*b +: 8] <= wdata[8*b +: 8];
          end
        end
      end
    end
  end

  always_comb begin
    case (araddr)
      reg_ctrl:        rd_word = {31'b0, run};
      reg_limit:       rd_word = 32'(limit);
      reg_status:      rd_word = {30'b0, run, stat_done};
      reg_cycles:      rd_word = cycles;
      reg_acks:        rd_word = 32'(acks);
      reg_timeouts:    rd_word = 32'(timeouts);
      reg_checksum_lo: rd_word = checksum[31:0];
      reg_checksum_hi: rd_word = checksum[63:32];
      default:         rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      if (arready) begin  // handshake completes now, data follows next cycle
        arready <= 1'b0;
        rvalid  <= 1'b1;
      end else if (arvalid && !rvalid) begin
        arready <= 1'b1;
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (arready && arvalid) begin
      rdata <= rd_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      run        <= 1'b0;
      stat_done  <= 1'b0;
      finished_q <= 1'b0;
      cycles     <= '0;
      acks       <= '0;
      timeouts   <= '0;
      checksum   <= '0;
    end else begin
      finished_q <= finished;
      if (start) begin
        run       <= 1'b1;
        stat_done <= 1'b0;
        cycles    <= '0;
        acks      <= '0;
        timeouts  <= '0;
        checksum  <= '0;
      end else if (run) begin
        cycles <= cycles + 1'b1;
        if (done) begin
          acks     <= acks + 1'b1;
          checksum <= checksum ^ rdata_in;
        end
        if (timeout) begin
          timeouts <= timeouts + 1'b1;
        end
        if (finished && !finished_q) begin  // finished stays high from the previous run
          run       <= 1'b0;
          stat_done <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: traffic_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request source, one transaction at a time until
// the host limit is reached, then raises finished
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module traffic_gen #(
  parameter int ADDR_W = memspeed_pkg::addr_w
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              run,
  input  logic [memspeed_pkg::count_w-1:0] limit,
  output logic                              req,
  output memspeed_pkg::op_t                 op,
  output logic [ADDR_W-1:0]                 addr,
  output logic [memspeed_pkg::data_w-1:0]  wdata,
  input  logic                              done,
  input  logic                              timeout,
  output logic                              finished
);
  import memspeed_pkg::*;

  typedef enum logic [1:0] {
    st_issue,
    st_wait,
    st_gap
  } state_t;

  state_t             state;
  logic [count_w-1:0] count;
  logic               run_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_gap;
      count    <= '0;
      run_q    <= 1'b0;
      finished <= 1'b0;
    end else begin
      run_q <= run;
      if (run && !run_q) begin  // a new run restarts the pattern
        state    <= st_gap;
        count    <= '0;
        finished <= 1'b0;
      end else begin
        case (state)
          st_issue: state <= st_wait;
          st_wait: begin
            if (done || timeout) begin
              count <= count + 1'b1;
              state <= st_gap;
            end
          end
          default: begin
            if (run && !finished) begin
              if (count == limit) begin
                finished <= 1'b1;
              end else begin
                state <= st_issue;
              end
            end
          end
        endcase
      end
    end
  end

  assign req = (state == st_issue);  // one-cycle strobe, the arbiter latches it

  always_comb begin
    if (count[1] && count[0]) begin
      op   = op_data_write;
      addr = count[ADDR_W-1:0] ^ ADDR_W'(data_scramble);
    end else if (!count[0]) begin
      op   = op_inst_read;
      addr = count[ADDR_W-1:0] ^ ADDR_W'(inst_scramble);
    end else begin
      op   = op_data_read;
      addr = count[ADDR_W-1:0] ^ ADDR_W'(data_scramble);
    end
  end

  assign wdata = {4{count[15:0]}};

endmodule

`default_nettype wire
